//--- verilog/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;

	// Register format
	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic [4:0] shamt;
		funct_t   funct;
	} r_fmt_t;

	// Immediate format
	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_ADDIU = 6'b001001;
	localparam opcode_t OP_SLTI  = 6'b001010;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_XORI  = 6'b001110;
	localparam opcode_t OP_LUI   = 6'b001111;
	localparam opcode_t OP_LW    = 6'b100011;
	localparam opcode_t OP_SW    = 6'b101011;

	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

endpackage

//--- verilog/fetch_unit.sv
module fetch_unit #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              imem_we,
	input  logic [7:0]        imem_addr,
	input  mips_pkg::word_t   imem_wdata,
	input  logic              start,
	input  logic [7:0]        run_len,
	input  logic              busy,
	output logic              issuing,
	output logic              f_valid,
	output mips_pkg::instr_u  f_instr
);
	import mips_pkg::*;

	word_t imem [IMEM_DEPTH];

	logic [7:0] pc;     // word index
	logic [7:0] remain; // issues left in this run

	// Run control
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			issuing <= 1'b0;
			pc      <= '0;
			remain  <= '0;
		end else if (start && !busy) begin
			issuing <= (run_len != 8'd0);
			pc      <= '0;
			remain  <= run_len;
		end else if (issuing) begin
			remain <= remain - 8'd1;
			if (remain == 8'd1) begin
				issuing <= 1'b0; // back to idle
				pc      <= '0;
			end else begin
				pc <= pc + 8'd1;
			end
		end
	end

	// Load port and synchronous instruction read
	always_ff @(posedge clock) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
		if (issuing) begin
			f_instr <= instr_u'(imem[pc]);
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			f_valid <= 1'b0;
		end else begin
			f_valid <= issuing;
		end
	end

endmodule

//--- verilog/decode_stage.sv
module decode_stage (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               f_valid,
	input  mips_pkg::instr_u   f_instr,
	input  mips_pkg::word_t    rs_data,
	input  mips_pkg::word_t    rt_data,
	output mips_pkg::reg_idx_t rs_idx,
	output mips_pkg::reg_idx_t rt_idx,
	output logic               d_valid,
	output mips_pkg::alu_op_e  d_op,
	output mips_pkg::word_t    d_a,
	output mips_pkg::word_t    d_b,
	output mips_pkg::word_t    d_store_data,
	output mips_pkg::reg_idx_t d_dest,
	output logic               d_is_load,
	output logic               d_is_store,
	output logic               d_writes
);
	import mips_pkg::*;

	alu_op_e  op_c;
	word_t    a_c;
	word_t    b_c;
	reg_idx_t dest_c;
	logic     load_c;
	logic     store_c;
	logic     writes_c;
	word_t    imm_sx;
	word_t    imm_zx;

	assign rs_idx = f_instr.r.rs;
	assign rt_idx = f_instr.r.rt;

	assign imm_sx = {{16{f_instr.i.imm[15]}}, f_instr.i.imm};
	assign imm_zx = {16'h0000, f_instr.i.imm};

	always_comb begin
		op_c     = ALU_ADD;
		a_c      = rs_data;
		b_c      = rt_data;
		dest_c   = f_instr.i.rt; // I-type writes rt
		load_c   = 1'b0;
		store_c  = 1'b0;
		writes_c = 1'b1;
		case (f_instr.r.opcode)
			OP_RTYPE: begin
				dest_c = f_instr.r.rd;
				case (f_instr.r.funct)
					FN_ADD, FN_ADDU: op_c = ALU_ADD;
					FN_SUB, FN_SUBU: op_c = ALU_SUB;
					FN_AND:  op_c = ALU_AND;
					FN_OR:   op_c = ALU_OR;
					FN_XOR:  op_c = ALU_XOR;
					FN_NOR:  op_c = ALU_NOR;
					FN_SLT:  op_c = ALU_SLT;
					FN_SLTU: op_c = ALU_SLTU;
					FN_SLL, FN_SRL, FN_SRA: begin
						// Shifts work on rt by shamt
						a_c = rt_data;
						b_c = {27'd0, f_instr.r.shamt};
						if (f_instr.r.funct == FN_SLL) op_c = ALU_SLL;
						else if (f_instr.r.funct == FN_SRL) op_c = ALU_SRL;
						else op_c = ALU_SRA;
					end
					default: writes_c = 1'b0; // no-op
				endcase
			end
			OP_ADDI, OP_ADDIU: b_c = imm_sx;
			OP_SLTI: begin
				op_c = ALU_SLT;
				b_c  = imm_sx;
			end
			OP_ORI: begin
				op_c = ALU_OR;
				b_c  = imm_zx;
			end
			OP_XORI: begin
				op_c = ALU_XOR;
				b_c  = imm_zx;
			end
			OP_LUI: begin
				op_c = ALU_LUI;
				b_c  = imm_zx;
			end
			OP_LW: begin
				b_c    = imm_sx;
				load_c = 1'b1;
			end
			OP_SW: begin
				b_c      = imm_sx;
				store_c  = 1'b1;
				writes_c = 1'b0;
			end
			default: writes_c = 1'b0;
		endcase
	end

	// Decode/execute register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			d_valid    <= 1'b0;
			d_is_load  <= 1'b0;
			d_is_store <= 1'b0;
			d_writes   <= 1'b0;
		end else begin
			d_valid    <= f_valid;
			d_is_load  <= f_valid && load_c;
			d_is_store <= f_valid && store_c;
			d_writes   <= f_valid && writes_c && (dest_c != 5'd0);
		end
	end

	always_ff @(posedge clock) begin
		d_op         <= op_c;
		d_a          <= a_c;
		d_b          <= b_c;
		d_store_data <= rt_data;
		d_dest       <= dest_c;
	end

endmodule

//--- verilog/reg_file.sv
module reg_file (
	input  logic               clock,
	input  logic               rst_n,
	input  mips_pkg::reg_idx_t rs_idx,
	input  mips_pkg::reg_idx_t rt_idx,
	input  logic               wb_we,
	input  mips_pkg::reg_idx_t wb_rd,
	input  mips_pkg::word_t    wb_data,
	output mips_pkg::word_t    rs_data,
	output mips_pkg::word_t    rt_data
);
	import mips_pkg::*;

	word_t regs [32];

	// Register zero reads zero and a same-cycle write passes through
	function automatic word_t read_port(reg_idx_t idx);
		if (idx == 5'd0) return '0;
		if (wb_we && (wb_rd == idx)) return wb_data;
		return regs[idx];
	endfunction

	always_comb begin
		rs_data = read_port(rs_idx);
		rt_data = read_port(rt_idx);
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we && (wb_rd != 5'd0)) begin
			regs[wb_rd] <= wb_data;
		end
	end

endmodule

//--- verilog/alu_stage.sv
module alu_stage (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               d_valid,
	input  mips_pkg::alu_op_e  d_op,
	input  mips_pkg::word_t    d_a,
	input  mips_pkg::word_t    d_b,
	input  mips_pkg::word_t    d_store_data,
	input  mips_pkg::reg_idx_t d_dest,
	input  logic               d_is_load,
	input  logic               d_is_store,
	input  logic               d_writes,
	output logic               x_valid,
	output mips_pkg::word_t    x_result,
	output mips_pkg::word_t    x_store_data,
	output mips_pkg::reg_idx_t x_dest,
	output logic               x_is_load,
	output logic               x_is_store,
	output logic               x_writes
);
	import mips_pkg::*;

	word_t    res;
	logic [4:0] sa;

	assign sa = d_b[4:0];

	always_comb begin
		case (d_op)
			ALU_ADD:  res = d_a + d_b; // also load/store address
			ALU_SUB:  res = d_a - d_b;
			ALU_AND:  res = d_a & d_b;
			ALU_OR:   res = d_a | d_b;
			ALU_XOR:  res = d_a ^ d_b;
			ALU_NOR:  res = ~(d_a | d_b);
			ALU_SLT:  res = {31'd0, $signed(d_a) < $signed(d_b)};
			ALU_SLTU: res = {31'd0, d_a < d_b};
			ALU_SLL:  res = d_a << sa;
			ALU_SRL:  res = d_a >> sa;
			ALU_SRA:  res = word_t'($signed(d_a) >>> sa);
			ALU_LUI:  res = {d_b[15:0], 16'h0000};
			default:  res = d_a + d_b;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			x_valid    <= 1'b0;
			x_is_load  <= 1'b0;
			x_is_store <= 1'b0;
			x_writes   <= 1'b0;
		end else begin
			x_valid    <= d_valid;
			x_is_load  <= d_valid && d_is_load;
			x_is_store <= d_valid && d_is_store;
			x_writes   <= d_valid && d_writes;
		end
	end

	always_ff @(posedge clock) begin
		x_result     <= res;
		x_store_data <= d_store_data;
		x_dest       <= d_dest;
	end

endmodule

//--- verilog/mem_stage.sv
module mem_stage #(
	parameter int DMEM_DEPTH = 256
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               x_valid,
	input  mips_pkg::word_t    x_result,
	input  mips_pkg::word_t    x_store_data,
	input  mips_pkg::reg_idx_t x_dest,
	input  logic               x_is_load,
	input  logic               x_is_store,
	input  logic               x_writes,
	output logic               w_valid,
	output logic               wb_we,
	output mips_pkg::reg_idx_t wb_rd,
	output mips_pkg::word_t    wb_data
);
	import mips_pkg::*;

	localparam int AW = $clog2(DMEM_DEPTH);

	word_t dmem [DMEM_DEPTH];

	logic [AW-1:0] addr;
	word_t         load_word;
	word_t         alu_word;
	logic          w_load;

	assign addr = x_result[AW+1:2]; // word address

	always_ff @(posedge clock) begin
		if (x_valid && x_is_store) begin
			dmem[addr] <= x_store_data;
		end
		load_word <= dmem[addr];
		alu_word  <= x_result;
		wb_rd     <= x_dest;
	end

	// Memory/writeback register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			w_valid <= 1'b0;
			wb_we   <= 1'b0;
			w_load  <= 1'b0;
		end else begin
			w_valid <= x_valid;
			wb_we   <= x_valid && x_writes;
			w_load  <= x_valid && x_is_load;
		end
	end

	// Writeback select
	assign wb_data = w_load ? load_word : alu_word;

endmodule

//--- verilog/mips_pipe.sv
module mips_pipe #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               imem_we,
	input  logic [7:0]         imem_addr,
	input  mips_pkg::word_t    imem_wdata,
	input  logic               start,
	input  logic [7:0]         run_len,
	output logic               busy,
	output logic               wb_valid,
	output mips_pkg::reg_idx_t wb_rd,
	output mips_pkg::word_t    wb_data
);
	import mips_pkg::*;

	logic     issuing;
	logic     f_valid;
	instr_u   f_instr;

	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t    rs_data;
	word_t    rt_data;

	logic     d_valid;
	alu_op_e  d_op;
	word_t    d_a;
	word_t    d_b;
	word_t    d_store_data;
	reg_idx_t d_dest;
	logic     d_is_load;
	logic     d_is_store;
	logic     d_writes;

	logic     x_valid;
	word_t    x_result;
	word_t    x_store_data;
	reg_idx_t x_dest;
	logic     x_is_load;
	logic     x_is_store;
	logic     x_writes;

	logic     w_valid;

	// Anything still in flight keeps the core busy
	assign busy = issuing | f_valid | d_valid | x_valid | w_valid;

	fetch_unit #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) fetch_i (
		.clock(clock), .rst_n(rst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.start(start), .run_len(run_len), .busy(busy),
		.issuing(issuing), .f_valid(f_valid), .f_instr(f_instr)
	);

	decode_stage decode_i (
		.clock(clock), .rst_n(rst_n),
		.f_valid(f_valid), .f_instr(f_instr),
		.rs_data(rs_data), .rt_data(rt_data),
		.rs_idx(rs_idx), .rt_idx(rt_idx),
		.d_valid(d_valid), .d_op(d_op), .d_a(d_a), .d_b(d_b),
		.d_store_data(d_store_data), .d_dest(d_dest),
		.d_is_load(d_is_load), .d_is_store(d_is_store), .d_writes(d_writes)
	);

	reg_file regs_i (
		.clock(clock), .rst_n(rst_n),
		.rs_idx(rs_idx), .rt_idx(rt_idx),
		.wb_we(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	alu_stage alu_i (
		.clock(clock), .rst_n(rst_n),
		.d_valid(d_valid), .d_op(d_op), .d_a(d_a), .d_b(d_b),
		.d_store_data(d_store_data), .d_dest(d_dest),
		.d_is_load(d_is_load), .d_is_store(d_is_store), .d_writes(d_writes),
		.x_valid(x_valid), .x_result(x_result), .x_store_data(x_store_data),
		.x_dest(x_dest), .x_is_load(x_is_load), .x_is_store(x_is_store),
		.x_writes(x_writes)
	);

	mem_stage #(
		.DMEM_DEPTH(DMEM_DEPTH)
	) mem_i (
		.clock(clock), .rst_n(rst_n),
		.x_valid(x_valid), .x_result(x_result), .x_store_data(x_store_data),
		.x_dest(x_dest), .x_is_load(x_is_load), .x_is_store(x_is_store),
		.x_writes(x_writes),
		.w_valid(w_valid),
		.wb_we(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

//--- verification/mips_pipe_tb.sv
module mips_pipe_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mips_pkg::*;

	localparam int RESET_CYCLES = 8;

	logic       clock = 1'b0;
	logic       rst_n;
	logic       imem_we;
	logic [7:0] imem_addr;
	word_t      imem_wdata;
	logic       start;
	logic [7:0] run_len;
	logic       busy;
	logic       wb_valid;
	reg_idx_t   wb_rd;
	word_t      wb_data;

	int cyc = 0;
	int cycle_limit = RESET_CYCLES + 10; // grows with every program
	int value_errors = 0;
	int other_errors = 0;
	logic [15:0] lfsr_state = 16'd38713;

	word_t    prog [$];
	int       ev_cyc [$];
	reg_idx_t ev_rd [$];
	word_t    ev_data [$];
	word_t    model_regs [32];
	word_t    model_mem [256];

	mips_pipe #(
		.IMEM_DEPTH(256),
		.DMEM_DEPTH(256)
	) dut_i (
		.clock(clock), .rst_n(rst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.start(start), .run_len(run_len), .busy(busy),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	always #4 clock = ~clock;

	always @(posedge clock) cyc <= cyc + 1;

	// Register writes as seen at the top level
	always @(negedge clock) begin
		if (rst_n && wb_valid) begin
			ev_cyc.push_back(cyc);
			ev_rd.push_back(wb_rd);
			ev_data.push_back(wb_data);
		end
	end

	always @(negedge clock) begin
		if (cyc > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output word_t v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t rtype_word(funct_t fn, int rd, int rs, int rt, int sh);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic word_t itype_word(opcode_t op, int rt, int rs, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic void put(word_t w);
		prog.push_back(w);
	endfunction

	function automatic void pad_nops(int k);
		for (int i = 0; i < k; i++) begin
			prog.push_back(32'h0000_0000); // SLL r0, r0, 0
		end
	endfunction

	function automatic logic signed_less(word_t x, word_t y);
		if (x[31] != y[31]) return x[31]; // negative one is smaller
		return x < y;
	endfunction

	// Reference model, one instruction in program order
	function automatic void model_exec(input word_t ins, output logic wr,
			output reg_idx_t rd, output word_t val);
		word_t a;
		word_t b;
		word_t sx;
		word_t zx;
		word_t addr;
		logic [4:0] sh;
		a    = model_regs[ins[25:21]];
		b    = model_regs[ins[20:16]];
		sx   = {{16{ins[15]}}, ins[15:0]};
		zx   = {16'h0000, ins[15:0]};
		addr = a + sx;
		sh   = ins[10:6];
		wr   = 1'b1;
		rd   = ins[20:16];
		val  = '0;
		case (ins[31:26])
			OP_RTYPE: begin
				rd = ins[15:11];
				case (ins[5:0])
					FN_ADD, FN_ADDU: val = a + b;
					FN_SUB, FN_SUBU: val = a - b;
					FN_AND:  val = a & b;
					FN_OR:   val = a | b;
					FN_XOR:  val = a ^ b;
					FN_NOR:  val = ~(a | b);
					FN_SLT:  val = {31'd0, signed_less(a, b)};
					FN_SLTU: val = {31'd0, a < b};
					FN_SLL:  val = b << sh;
					FN_SRL:  val = b >> sh;
					FN_SRA:  val = (b >> sh) | (b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
					default: wr = 1'b0;
				endcase
			end
			OP_ADDI, OP_ADDIU: val = a + sx;
			OP_SLTI: val = {31'd0, signed_less(a, sx)};
			OP_ORI:  val = a | zx;
			OP_XORI: val = a ^ zx;
			OP_LUI:  val = {ins[15:0], 16'h0000};
			OP_LW:   val = model_mem[addr[9:2]];
			OP_SW: begin
				wr = 1'b0;
				model_mem[addr[9:2]] = b;
			end
			default: wr = 1'b0;
		endcase
		if (rd == 5'd0) wr = 1'b0;
		if (wr) model_regs[rd] = val;
	endfunction

	task automatic check_reg_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", what, got, exp);
			value_errors++;
		end
	endtask

	// Load prog, start it, wait for busy to drop, compare writes
	task automatic run_program(input string name);
		int n;
		int start_cyc;
		int end_cyc;
		int found;
		logic wr;
		reg_idx_t rd;
		word_t val;
		int exp_off [$];
		reg_idx_t exp_rd [$];
		word_t exp_val [$];
		n = prog.size();
		cycle_limit += 2 * n + 10;
		for (int i = 0; i < n; i++) begin
			model_exec(prog[i], wr, rd, val);
			if (wr) begin
				exp_off.push_back(i);
				exp_rd.push_back(rd);
				exp_val.push_back(val);
			end
		end
		ev_cyc.delete();
		ev_rd.delete();
		ev_data.delete();
		for (int i = 0; i < n; i++) begin
			@(posedge clock);
			imem_we    <= 1'b1;
			imem_addr  <= 8'(i);
			imem_wdata <= prog[i];
		end
		@(posedge clock);
		imem_we <= 1'b0;
		start   <= 1'b1;
		run_len <= 8'(n);
		@(negedge clock);
		start_cyc = cyc;
		@(posedge clock);
		start <= 1'b0;
		@(negedge clock);
		while (busy) @(negedge clock);
		end_cyc = cyc;
		if (end_cyc != start_cyc + 5 + n) begin
			$display("%s: busy fell in cycle %0d instead of cycle %0d", name, end_cyc,
				start_cyc + 5 + n);
			other_errors++;
		end
		if (ev_cyc.size() != exp_off.size()) begin
			$display("%s: saw %0d register writes but expected %0d", name, ev_cyc.size(),
				exp_off.size());
			other_errors++;
		end
		foreach (ev_rd[j]) begin
			if (ev_rd[j] == 5'd0) begin
				$display("%s: a write to register zero was reported", name);
				other_errors++;
			end
		end
		foreach (exp_off[k]) begin
			found = -1;
			foreach (ev_cyc[j]) begin
				if (ev_cyc[j] == start_cyc + 5 + exp_off[k]) found = j;
			end
			if (found < 0) begin
				$display("%s: instruction %0d did not write back in cycle %0d", name,
					exp_off[k], start_cyc + 5 + exp_off[k]);
				other_errors++;
			end else begin
				check_reg_idx($sformatf("wb_rd (%s, instr %0d)", name, exp_off[k]),
					ev_rd[found], exp_rd[k]);
				check_word($sformatf("wb_data (%s, instr %0d)", name, exp_off[k]),
					ev_data[found], exp_val[k]);
			end
		end
	endtask

	task automatic arith_logic_ops();
		prog.delete();
		put(itype_word(OP_ADDIU, 1, 0, 16'h1234));
		put(itype_word(OP_ADDIU, 2, 0, 16'hF00F)); // sign-extended
		pad_nops(2);
		put(rtype_word(FN_ADDU, 3, 1, 2, 0));
		put(rtype_word(FN_ADD, 4, 2, 1, 0));
		put(rtype_word(FN_SUBU, 5, 1, 2, 0));
		put(rtype_word(FN_SUB, 6, 2, 1, 0));
		put(rtype_word(FN_AND, 7, 1, 2, 0));
		put(rtype_word(FN_OR, 8, 1, 2, 0));
		put(rtype_word(FN_XOR, 9, 1, 2, 0));
		put(rtype_word(FN_NOR, 10, 1, 2, 0));
		run_program("arith_logic_ops");
	endtask

	task automatic shifts_and_compares();
		prog.delete();
		put(itype_word(OP_ADDIU, 1, 0, 16'hFFF8)); // -8
		put(itype_word(OP_ADDIU, 2, 0, 16'h0070));
		pad_nops(2);
		put(rtype_word(FN_SLL, 3, 0, 1, 4));
		put(rtype_word(FN_SRL, 4, 0, 1, 4));
		put(rtype_word(FN_SRA, 5, 0, 1, 4));
		put(rtype_word(FN_SLL, 6, 0, 2, 27));
		put(rtype_word(FN_SRL, 7, 0, 2, 2));
		put(rtype_word(FN_SRA, 8, 0, 2, 1));
		put(rtype_word(FN_SLT, 9, 1, 2, 0));   // signed and unsigned disagree
		put(rtype_word(FN_SLTU, 10, 1, 2, 0));
		put(rtype_word(FN_SLT, 11, 2, 1, 0));
		put(rtype_word(FN_SLTU, 12, 2, 1, 0));
		run_program("shifts_and_compares");
	endtask

	task automatic immediate_ops();
		prog.delete();
		put(itype_word(OP_ADDIU, 1, 0, 16'hFF9C)); // -100
		put(itype_word(OP_ORI, 2, 0, 16'h8001));
		put(itype_word(OP_XORI, 3, 0, 16'hF0F0));
		put(itype_word(OP_LUI, 5, 0, 16'hDEAD));
		put(itype_word(OP_SLTI, 4, 1, 16'hFFCE));
		put(itype_word(OP_SLTI, 7, 1, 16'hFF00));
		put(itype_word(OP_ORI, 5, 5, 16'hBEEF));
		put(itype_word(OP_XORI, 6, 2, 16'hFFFF));
		run_program("immediate_ops");
	endtask

	task automatic store_load();
		prog.delete();
		put(itype_word(OP_ADDIU, 1, 0, 16'h0040)); // base address
		put(itype_word(OP_ADDIU, 2, 0, 16'hFFB3));
		put(itype_word(OP_LUI, 3, 0, 16'hCAFE));
		pad_nops(2);
		put(itype_word(OP_ORI, 3, 3, 16'hF00D));
		put(itype_word(OP_SW, 2, 1, 16'h0008));
		pad_nops(2);
		put(itype_word(OP_SW, 3, 1, 16'hFFFC));
		put(itype_word(OP_ADDIU, 4, 1, 16'h0010));
		pad_nops(2);
		put(itype_word(OP_LW, 5, 4, 16'hFFF8));
		put(itype_word(OP_LW, 6, 4, 16'hFFEC));
		pad_nops(2);
		put(rtype_word(FN_ADDU, 7, 5, 6, 0));
		run_program("store_load");
	endtask

	task automatic zero_register();
		prog.delete();
		put(itype_word(OP_ADDIU, 0, 0, 16'h1234));
		put(itype_word(OP_ORI, 0, 0, 16'hFFFF));
		put(rtype_word(FN_NOR, 0, 0, 0, 0));
		put(itype_word(OP_LUI, 0, 0, 16'h5555));
		pad_nops(2);
		put(rtype_word(FN_ADDU, 8, 0, 0, 0));
		put(itype_word(OP_ORI, 9, 0, 16'h0001));
		put(itype_word(OP_LW, 0, 0, 16'h0048));
		run_program("zero_register");
	endtask

	task automatic random_alu_ops();
		word_t seeds [8];
		word_t v;
		int rs;
		int rt;
		prog.delete();
		for (int k = 0; k < 8; k++) begin
			take_bits(32, seeds[k]);
			put(itype_word(OP_LUI, k + 1, 0, seeds[k][31:16]));
		end
		for (int k = 0; k < 8; k++) begin
			put(itype_word(OP_ORI, k + 1, k + 1, seeds[k][15:0]));
		end
		pad_nops(2);
		for (int j = 0; j < 20; j++) begin
			take_bits(4, v);
			rs = int'(v[3:0]) + 1;
			take_bits(4, v);
			rt = int'(v[3:0]) + 1;
			take_bits(1, v);
			put(rtype_word(v[0] ? FN_XOR : FN_ADDU, 9 + (j % 8), rs, rt, 0));
			pad_nops(2); // keeps every op three apart
		end
		run_program("random_alu_ops");
	endtask

	initial begin
		rst_n      = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = 8'd0;
		imem_wdata = '0;
		start      = 1'b0;
		run_len    = 8'd0;
		foreach (model_regs[i]) model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);
		arith_logic_ops();
		shifts_and_compares();
		immediate_ops();
		store_load();
		zero_register();
		random_alu_ops();
		$display("Checks done: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors + other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- mips_pipe.f
verilog/mips_pkg.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/alu_stage.sv
verilog/mem_stage.sv
verilog/mips_pipe.sv
verification/mips_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the pipeline testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mips_pipe_tb -f mips_pipe.f -o mips_pipe_sim || exit 1

out=$(./obj_dir/mips_pipe_sim)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
